// File: rtl/vga_macros.svh
/* VGA constants for the framebuffer subsystem.
   Fixed 640x480 raster timing, line geometry and APB register offsets. */
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Horizontal timing in pixel clocks.
`define VGA_H_PULSE         96
`define VGA_H_BACK          48
`define VGA_H_ACTIVE        640
`define VGA_H_PERIOD        800

// Vertical timing in lines.
`define VGA_V_PULSE         2
`define VGA_V_BACK          29
`define VGA_V_ACTIVE        480
`define VGA_V_PERIOD        521

// One line of 8-bit pixels packed four to a word.
`define VGA_WORDS_PER_LINE  160

// Register offsets on the APB port.
`define VGA_REG_CTRL        32'h0000_0000
`define VGA_REG_BASE        32'h0000_0004
`define VGA_REG_STATUS      32'h0000_0008

`endif

// File: rtl/vga_pkg.sv
/* VGA framebuffer types.
   Word, pixel and raster coordinate widths, plus the line fetch states. */
package vga_pkg;

	// SRAM data, SRAM address and APB data.
	typedef logic [31:0] word_t;

	// One 8-bit pixel colour.
	typedef logic [7:0] pixel_t;

	// Raster counters and active coordinates, up to 2047.
	typedef logic [10:0] coord_t;

	// Line fetch progress within one raster line.
	typedef enum logic [1:0] {
		IDLE,  // No fetch this line.
		FETCH, // Streaming words from SRAM.
		DONE   // Line complete, waiting for line start.
	} fetch_state_t;

endpackage

// File: rtl/vga_apb_regs.sv
/* VGA register block on APB.
   Control, framebuffer base and read-only status with a sticky underrun flag. */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_apb_regs (
	input  logic           clk,
	input  logic           rst,
	input  logic           psel,
	input  logic           penable,
	input  logic           pwrite,
	input  vga_pkg::word_t paddr,
	input  vga_pkg::word_t pwdata,
	output vga_pkg::word_t prdata,
	output logic           pready,
	output logic           pslverr,
	input  logic           vblank,
	input  logic           underrun_set,
	output logic           ctrl_enable,
	output vga_pkg::word_t fb_base
);
	import vga_pkg::*;

	logic access;
	logic mapped;
	logic underrun_clear;
	logic underrun;

	assign access = psel && penable; // Access phase.
	assign mapped = (paddr == `VGA_REG_CTRL) || (paddr == `VGA_REG_BASE) ||
			(paddr == `VGA_REG_STATUS);
	assign pready = 1'b1; // Zero wait states.
	assign pslverr = access && !mapped;
	assign underrun_clear = access && pwrite && (paddr == `VGA_REG_CTRL);

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_enable <= 1'b0;
			fb_base <= '0;
		end else if (access && pwrite) begin
			if (paddr == `VGA_REG_CTRL)
				ctrl_enable <= pwdata[0];
			else if (paddr == `VGA_REG_BASE)
				fb_base <= pwdata;
		end
	end

	// A new underrun wins over a clear in the same cycle.
	always_ff @(posedge clk) begin
		if (rst)
			underrun <= 1'b0;
		else if (underrun_set)
			underrun <= 1'b1;
		else if (underrun_clear)
			underrun <= 1'b0;
	end

	always_comb begin
		case (paddr)
			`VGA_REG_CTRL:   prdata = {31'b0, ctrl_enable};
			`VGA_REG_BASE:   prdata = fb_base;
			`VGA_REG_STATUS: prdata = {30'b0, underrun, vblank};
			default:         prdata = '0; // Unmapped, flagged by pslverr.
		endcase
	end

	// Setup phase is followed by the access phase with the same address.
	a_apb_setup_access: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable && $stable(paddr));

endmodule

// File: rtl/vga_timing.sv
/* VGA raster timing generator.
   Counts pixels and lines, marks the active window and flags line and frame starts. */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_timing (
	input  logic            clk,
	input  logic            rst,
	output vga_pkg::coord_t h_cnt,
	output vga_pkg::coord_t v_cnt,
	output vga_pkg::coord_t pix_x,
	output vga_pkg::coord_t pix_y,
	output logic            active,
	output logic            line_start,
	output logic            frame_start,
	output logic            vblank
);
	import vga_pkg::*;

	localparam coord_t H_START = coord_t'(`VGA_H_PULSE + `VGA_H_BACK);
	localparam coord_t H_END   = coord_t'(`VGA_H_PULSE + `VGA_H_BACK + `VGA_H_ACTIVE);
	localparam coord_t V_START = coord_t'(`VGA_V_PULSE + `VGA_V_BACK);
	localparam coord_t V_END   = coord_t'(`VGA_V_PULSE + `VGA_V_BACK + `VGA_V_ACTIVE);
	localparam coord_t H_LAST  = coord_t'(`VGA_H_PERIOD - 1);
	localparam coord_t V_LAST  = coord_t'(`VGA_V_PERIOD - 1);

	logic h_act;
	logic v_act;

	// Last clock of a line and of a frame.
	assign line_start = (h_cnt == H_LAST);
	assign frame_start = line_start && (v_cnt == V_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_start) begin
			h_cnt <= '0;
			if (frame_start)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + coord_t'(1);
		end else begin
			h_cnt <= h_cnt + coord_t'(1);
		end
	end

	// Active window after sync pulse and back porch.
	assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
	assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);
	assign active = h_act && v_act;
	assign vblank = !v_act;

	// Zero outside the window, which keeps the line buffer index in range.
	assign pix_x = active ? (h_cnt - H_START) : '0;
	assign pix_y = active ? (v_cnt - V_START) : '0;

endmodule

// File: rtl/vga_line_fetch.sv
/* VGA line fetcher.
   Prefetches the next line from SRAM into a ping-pong buffer and flags underruns. */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_line_fetch (
	input  logic            clk,
	input  logic            rst,
	input  logic            line_start,
	input  logic            frame_start,
	input  vga_pkg::coord_t v_cnt,
	input  vga_pkg::coord_t pix_x,
	input  logic            ctrl_enable,
	input  vga_pkg::word_t  fb_base,
	output vga_pkg::word_t  sram_addr,
	output logic            sram_read,
	input  vga_pkg::word_t  sram_data,
	input  logic            sram_rdy,
	output vga_pkg::word_t  disp_word,
	output logic            frame_enable,
	output logic            underrun_set
);
	import vga_pkg::*;

	// A fetch starting at the end of line v fills row v - 29.
	localparam coord_t V_FETCH_LO = coord_t'(`VGA_V_PULSE + `VGA_V_BACK - 2);
	localparam coord_t V_FETCH_HI = coord_t'(`VGA_V_PULSE + `VGA_V_BACK + `VGA_V_ACTIVE - 3);
	localparam logic [7:0] LAST_WORD = 8'(`VGA_WORDS_PER_LINE - 1);

	word_t line_buf [0:1][0:`VGA_WORDS_PER_LINE-1];
	fetch_state_t state;
	word_t frame_base;
	word_t line_offset;
	coord_t row;
	coord_t next_row;
	coord_t restart_row;
	coord_t redo_row;
	logic next_valid;
	logic restart_valid;
	logic redo_valid;
	logic restart;
	logic [7:0] word_idx;
	logic disp_sel; // Half being displayed.
	logic xfer;

	// Base and enable only change at a frame boundary.
	always_ff @(posedge clk) begin
		if (rst)
			frame_enable <= 1'b0;
		else if (frame_start)
			frame_enable <= ctrl_enable;
	end

	always_ff @(posedge clk) begin
		if (frame_start)
			frame_base <= fb_base;
	end

	assign next_row = v_cnt - V_FETCH_LO;
	assign next_valid = frame_enable && (v_cnt >= V_FETCH_LO) && (v_cnt <= V_FETCH_HI);

	// A late fetch finishes its open request, then restarts on the new row.
	assign redo_row = line_start ? next_row : restart_row;
	assign redo_valid = line_start ? next_valid : restart_valid;

	assign xfer = sram_read && sram_rdy;
	assign sram_read = (state == FETCH);
	assign line_offset = word_t'(row) * word_t'(`VGA_H_ACTIVE);
	assign sram_addr = frame_base + line_offset + word_t'({word_idx, 2'b00});

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			row <= '0;
			word_idx <= '0;
			disp_sel <= 1'b0;
			restart <= 1'b0;
			restart_row <= '0;
			restart_valid <= 1'b0;
			underrun_set <= 1'b0;
		end else begin
			underrun_set <= line_start && (state == FETCH);
			if (line_start && state != FETCH)
				disp_sel <= !disp_sel; // Stale half stays on underrun.
			case (state)
				IDLE, DONE: begin
					if (line_start && next_valid) begin
						state <= FETCH;
						row <= next_row;
						word_idx <= '0;
					end else if (line_start) begin
						state <= IDLE;
					end
				end
				FETCH: begin
					if (line_start) begin
						restart <= 1'b1;
						restart_row <= next_row;
						restart_valid <= next_valid;
					end
					if (xfer) begin
						if (line_start || restart) begin
							restart <= 1'b0;
							row <= redo_row;
							word_idx <= '0;
							if (!redo_valid)
								state <= IDLE;
						end else if (word_idx == LAST_WORD) begin
							state <= DONE;
						end else begin
							word_idx <= word_idx + 8'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (xfer)
			line_buf[!disp_sel][word_idx] <= sram_data; // Back half.
	end

	assign disp_word = line_buf[disp_sel][pix_x[9:2]];

	// The SRAM request holds its address until it is accepted.
	a_sram_addr_stable: assert property (@(posedge clk) disable iff (rst)
		sram_read && !sram_rdy |=> sram_read && $stable(sram_addr));

endmodule

// File: rtl/vga_pixel_out.sv
/* VGA pixel output stage.
   Picks the pixel byte, blanks it and registers rgb with both syncs. */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_pixel_out (
	input  logic            clk,
	input  logic            rst,
	input  logic            active,
	input  logic            frame_enable,
	input  vga_pkg::coord_t pix_x,
	input  vga_pkg::word_t  disp_word,
	input  vga_pkg::coord_t h_cnt,
	input  vga_pkg::coord_t v_cnt,
	output vga_pkg::pixel_t rgb,
	output logic            hs,
	output logic            vs
);
	import vga_pkg::*;

	localparam coord_t H_PULSE = coord_t'(`VGA_H_PULSE);
	localparam coord_t V_PULSE = coord_t'(`VGA_V_PULSE);

	pixel_t pix_byte;

	// Leftmost pixel sits in the top byte.
	always_comb begin
		case (pix_x[1:0])
			2'd0:    pix_byte = disp_word[31:24];
			2'd1:    pix_byte = disp_word[23:16];
			2'd2:    pix_byte = disp_word[15:8];
			default: pix_byte = disp_word[7:0];
		endcase
	end

	// Same register stage for colour and syncs keeps them aligned.
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb <= '0;
			hs <= 1'b0;
			vs <= 1'b0;
		end else begin
			rgb <= (active && frame_enable) ? pix_byte : '0; // Blanking.
			hs <= (h_cnt >= H_PULSE); // Active low pulse.
			vs <= (v_cnt >= V_PULSE);
		end
	end

endmodule

// File: rtl/vga_fb.sv
/* VGA framebuffer display top level.
   APB register block feeding timing, line fetch and pixel output stages. */
`timescale 1ns/1ps

module vga_fb (
	input  logic            clk,
	input  logic            rst,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  vga_pkg::word_t  paddr,
	input  vga_pkg::word_t  pwdata,
	output vga_pkg::word_t  prdata,
	output logic            pready,
	output logic            pslverr,
	output vga_pkg::word_t  sram_addr,
	output logic            sram_read,
	input  vga_pkg::word_t  sram_data,
	input  logic            sram_rdy,
	output vga_pkg::pixel_t rgb,
	output logic            hs,
	output logic            vs
);
	import vga_pkg::*;

	word_t fb_base;
	word_t disp_word;
	coord_t h_cnt;
	coord_t v_cnt;
	coord_t pix_x;
	logic ctrl_enable;
	logic vblank;
	logic underrun_set;
	logic active;
	logic line_start;
	logic frame_start;
	logic frame_enable;

	vga_apb_regs u_regs (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .vblank(vblank), .underrun_set(underrun_set),
		.ctrl_enable(ctrl_enable), .fb_base(fb_base)
	);

	// Row index is not needed downstream, the fetcher works from v_cnt.
	vga_timing u_timing (
		.clk(clk), .rst(rst), .h_cnt(h_cnt), .v_cnt(v_cnt), .pix_x(pix_x),
		.pix_y(), .active(active), .line_start(line_start),
		.frame_start(frame_start), .vblank(vblank)
	);

	vga_line_fetch u_fetch (
		.clk(clk), .rst(rst), .line_start(line_start), .frame_start(frame_start),
		.v_cnt(v_cnt), .pix_x(pix_x), .ctrl_enable(ctrl_enable), .fb_base(fb_base),
		.sram_addr(sram_addr), .sram_read(sram_read), .sram_data(sram_data),
		.sram_rdy(sram_rdy), .disp_word(disp_word), .frame_enable(frame_enable),
		.underrun_set(underrun_set)
	);

	vga_pixel_out u_out (
		.clk(clk), .rst(rst), .active(active), .frame_enable(frame_enable),
		.pix_x(pix_x), .disp_word(disp_word), .h_cnt(h_cnt), .v_cnt(v_cnt),
		.rgb(rgb), .hs(hs), .vs(vs)
	);

endmodule

// File: tb/vga_clk_gen.sv
/* Testbench clock source with a 10 ns period. */
`timescale 1ns/1ps

module vga_clk_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #5 clk = ~clk; // Half of the 10 ns period.

endmodule

// File: tb/tb_vga_fb.sv
/* Testbench for the VGA framebuffer subsystem.
   Replays register and pixel cases, models the SRAM and checks the sync timing. */
`timescale 1ns/1ps
`include "vga_macros.svh"

module tb_vga_fb;
	import vga_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int FRAME_CYCLES = `VGA_H_PERIOD * `VGA_V_PERIOD;
	localparam int FIRST_PIX = `VGA_H_PULSE + `VGA_H_BACK; // Clocks from hs fall to pixel 0.
	localparam int FIRST_LINE = `VGA_V_PULSE + `VGA_V_BACK; // Lines from vs fall to row 0.
	localparam word_t SRAM_PATTERN = 32'h5a5a_5a5a;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	word_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;
	word_t sram_addr;
	logic sram_read;
	word_t sram_data;
	logic sram_rdy;
	pixel_t rgb;
	logic hs;
	logic vs;

	word_t case_mem [0:5*MAX_CASES-1]; // Five columns per case.
	int n_cases = 0;
	bit cases_loaded = 1'b0;
	bit failed = 1'b0;

	// Raster position as seen on the sync outputs.
	int cyc = 0;
	int hs_fall_cyc = 0;
	int vs_fall_cyc = 0;
	int frame_cnt = 0;
	int line_cnt = 0;
	bit prev_hs = 1'b0;
	bit prev_vs = 1'b0;
	bit seen_hs_fall = 1'b0;
	bit seen_vs_fall = 1'b0;

	bit sample_pending = 1'b0; // Pixel sample waiting for its position.
	int sample_frame;
	int sample_x;
	int sample_y;
	pixel_t sample_rgb;

	vga_clk_gen u_clk (.clk(clk));

	vga_fb u_dut (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .sram_addr(sram_addr), .sram_read(sram_read),
		.sram_data(sram_data), .sram_rdy(sram_rdy), .rgb(rgb), .hs(hs), .vs(vs)
	);

	task automatic stop_with_error(input string msg);
		failed = 1'b1;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// Setup phase, then access phase, sampled inside the access phase.
	task automatic apb_transfer(input bit write, input word_t addr, input word_t wdata,
		input word_t exp_data, input bit exp_err);
		word_t got_data;
		bit got_err;
		bit got_rdy;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		got_data = prdata; // Settled before the closing edge.
		got_err = pslverr;
		got_rdy = pready;
		@(posedge clk);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		check_flag("pready", got_rdy, 1'b1);
		check_flag("pslverr", got_err, exp_err);
		if (!write && !exp_err)
			check_word($sformatf("prdata at %h", addr), got_data, exp_data);
	endtask

	task automatic sample_pixel(input int frame, input int x, input int y, input pixel_t exp);
		sample_frame = frame;
		sample_x = x;
		sample_y = y;
		sample_rgb = exp;
		sample_pending = 1'b1;
		wait (!sample_pending); // Monitor clears it at the sample point.
	endtask

	// Ops: 0 write, 1 read, 2 pixel sample, 3 wait for frame start.
	task automatic run_case(input int idx);
		word_t op;
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		op = case_mem[5*idx];
		a = case_mem[5*idx+1];
		b = case_mem[5*idx+2];
		c = case_mem[5*idx+3];
		d = case_mem[5*idx+4];
		case (op)
			32'd0: apb_transfer(1'b1, a, b, '0, c[0]);
			32'd1: apb_transfer(1'b0, a, '0, b, c[0]);
			32'd2: sample_pixel(int'(a), int'(b), int'(c), pixel_t'(d));
			32'd3: wait (frame_cnt >= int'(a));
			default: stop_with_error($sformatf("Case %0d has an unknown operation.", idx));
		endcase
	endtask

	// SRAM model, ready at least every second cycle.
	initial begin : sram_model
		bit req_open;
		word_t req_addr;
		req_open = 1'b0;
		req_addr = '0;
		void'($urandom(32'hb953));
		forever begin
			@(negedge clk);
			if (req_open) begin // Request not yet accepted.
				check_flag("sram_read while waiting", sram_read, 1'b1);
				check_word("sram_addr while waiting", sram_addr, req_addr);
			end
			sram_data = sram_addr ^ SRAM_PATTERN;
			if (!sram_rdy)
				sram_rdy = 1'b1;
			else
				sram_rdy = ($urandom % 2) == 1;
			req_open = sram_read && !sram_rdy;
			req_addr = sram_addr;
		end
	end

	// Sync timing checks and pixel sampling.
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!rst) begin
			if (!hs && prev_hs) begin
				if (seen_hs_fall)
					check_word("hs period", word_t'(cyc - hs_fall_cyc), `VGA_H_PERIOD);
				seen_hs_fall = 1'b1;
				hs_fall_cyc = cyc;
				line_cnt = line_cnt + 1;
			end
			if (hs && !prev_hs && seen_hs_fall)
				check_word("hs low width", word_t'(cyc - hs_fall_cyc), `VGA_H_PULSE);
			if (!vs && prev_vs) begin
				if (seen_vs_fall)
					check_word("vs period", word_t'(cyc - vs_fall_cyc), FRAME_CYCLES);
				seen_vs_fall = 1'b1;
				vs_fall_cyc = cyc;
				frame_cnt = frame_cnt + 1;
				line_cnt = 0;
			end
			if (vs && !prev_vs && seen_vs_fall)
				check_word("vs low width", word_t'(cyc - vs_fall_cyc),
					`VGA_V_PULSE * `VGA_H_PERIOD);
			if (sample_pending && frame_cnt > sample_frame)
				stop_with_error("A pixel sample point had passed before it was requested.");
			if (sample_pending && frame_cnt == sample_frame &&
				line_cnt == FIRST_LINE + sample_y &&
				cyc - hs_fall_cyc == FIRST_PIX + sample_x) begin
				check_pixel($sformatf("rgb at frame %0d x %0d y %0d",
					sample_frame, sample_x, sample_y), rgb, sample_rgb);
				sample_pending = 1'b0;
			end
			prev_hs = hs;
			prev_vs = vs;
		end
	end

	initial begin : watchdog
		wait (cases_loaded);
		repeat ((n_cases + 3) * FRAME_CYCLES) @(posedge clk);
		stop_with_error("Timeout: the cases did not finish in the allowed number of frames.");
	end

	initial begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		sram_data = '0;
		sram_rdy = 1'b0;
		$readmemh("tb/vga_cases.txt", case_mem);
		while (n_cases < MAX_CASES && case_mem[5*n_cases] !== 'x)
			n_cases++;
		if (n_cases == 0) begin
			stop_with_error("No cases could be read from tb/vga_cases.txt.");
		end else begin
			cases_loaded = 1'b1;
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			for (int i = 0; i < n_cases; i++)
				run_case(i);
			if (!failed)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// File: vga_fb.f
+incdir+rtl
rtl/vga_pkg.sv
rtl/vga_apb_regs.sv
rtl/vga_timing.sv
rtl/vga_line_fetch.sv
rtl/vga_pixel_out.sv
rtl/vga_fb.sv
tb/vga_clk_gen.sv
tb/tb_vga_fb.sv

// File: Bender.yml
package:
  name: vga_fb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vga_pkg.sv
      - rtl/vga_apb_regs.sv
      - rtl/vga_timing.sv
      - rtl/vga_line_fetch.sv
      - rtl/vga_pixel_out.sv
      - rtl/vga_fb.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/vga_clk_gen.sv
      - tb/tb_vga_fb.sv

// File: tb/vga_cases.txt
// op addr/frame data/x err/y rgb; op 0 write, 1 read, 2 pixel sample, 3 wait for frame.
// All hex. Frame counts vs falls after reset, pixel rgb is the SRAM word byte ^ 5a.
0 00000004 00010000 0 00
0 00000000 00000001 0 00
0 0000000c 12345678 1 00
1 00000004 00010000 0 00
1 00000000 00000001 0 00
1 0000000c 00000000 1 00
1 00000008 00000001 0 00
2 00000001 00000007 3 de
0 00000004 00020000 0 00
2 00000001 0000027f 1df a6
2 00000002 00000102 64 a1
1 00000008 00000000 0 00
0 00000000 00000000 0 00
3 00000003 00000000 0 00
1 00000008 00000001 0 00
2 00000003 00000007 3 00
2 00000003 00000102 64 00
